// ==== verilog.f ====
hdl/uart_pkg.sv
hdl/baud_tick_gen.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/flag_buf.sv
hdl/uart_ff_buf.sv
tb/tb_clk_gen.sv
tb/tb_uart_ff_buf.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_uart_ff_buf
FILELIST := verilog.f
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the output
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_uart_ff_buf.sv ====
// Table-driven testbench for the UART top level.
// Sends serial frames on rx, writes host bytes and decodes the tx line at mid-bit.
`timescale 1ns/100ps
`default_nettype none

module tb_uart_ff_buf;
   import uart_pkg::*;

   localparam int BIT_CLKS      = DVSR * OVERSAMPLE;  // clocks per serial bit
   localparam int FRAME_CLKS    = 10 * BIT_CLKS;      // start, 8 data, stop
   localparam int NUM_FIXED     = 6;
   localparam int NUM_RANDOM    = 4;
   localparam int TABLE_LEN     = NUM_FIXED + NUM_RANDOM;
   localparam int WATCHDOG_CLKS = TABLE_LEN * 2 * FRAME_CLKS + 4 * FRAME_CLKS;

   typedef struct packed {
      uart_data_t rx_data;    // byte sent into rx
      uart_data_t tx_data;    // byte written by the host
      logic       read_late;  // left unread so the next frame overwrites it
   } stim_t;

   logic       clk;
   logic       rst_n;
   logic       rd_uart;
   logic       wr_uart;
   logic       rx;
   uart_data_t w_data;
   logic       tx_full;
   logic       rx_empty;
   logic       tx;
   uart_data_t r_data;

   stim_t      stim_q[$];
   int         errors;
   integer     seed;
   logic       pending;   // unread byte sitting in the rx buffer
   logic       have_rx;   // r_data holds a known byte
   uart_data_t last_rx;

   tb_clk_gen u_clk (
      .clk (clk)
   );

   uart_ff_buf dut0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd_uart  (rd_uart),
      .wr_uart  (wr_uart),
      .rx       (rx),
      .w_data   (w_data),
      .tx_full  (tx_full),
      .rx_empty (rx_empty),
      .tx       (tx),
      .r_data   (r_data)
   );

   // wait n rising edges, then settle 1 ns past the edge
   task automatic cycles(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic expect_bit(input string sig, input logic actual, input logic expected);
      assert (actual === expected) else begin
         errors++;
         $display("Mismatch at %0d ns: %s is %b, expected %b", $time, sig, actual, expected);
      end
   endtask

   task automatic expect_byte(input string sig, input uart_data_t actual,
                              input uart_data_t expected);
      assert (actual === expected) else begin
         errors++;
         $display("Mismatch at %0d ns: %s is %h, expected %h", $time, sig, actual, expected);
      end
   endtask

   function automatic stim_t make_entry(input uart_data_t rx_b, input uart_data_t tx_b,
                                        input logic late);
      stim_t e;
      e.rx_data   = rx_b;
      e.tx_data   = tx_b;
      e.read_late = late;
      return e;
   endfunction

   // 8N1 frame on rx with the LSB first
   task automatic send_rx_frame(input uart_data_t b);
      int i;
      rx = 1'b0;
      cycles(BIT_CLKS);
      for (i = 0; i < DBIT; i++) begin
         rx = b[i];
         cycles(BIT_CLKS);
      end
      rx = 1'b1;
      cycles(BIT_CLKS);
   endtask

   task automatic rx_side(input stim_t s);
      int limit;
      if (have_rx) begin
         expect_byte("r_data", r_data, last_rx);  // held since the last frame
      end
      expect_bit("rx_empty", rx_empty, !pending);
      send_rx_frame(s.rx_data);
      limit = 0;
      while (rx_empty !== 1'b0 && limit < BIT_CLKS) begin
         cycles(1);
         limit++;
      end
      assert (rx_empty === 1'b0) else begin
         errors++;
         $display("Receive buffer stayed empty after a full frame on rx");
      end
      expect_byte("r_data", r_data, s.rx_data);
      last_rx = s.rx_data;
      have_rx = 1'b1;
      if (s.read_late) begin
         pending = 1'b1;
      end else begin
         rd_uart = 1'b1;
         cycles(1);
         rd_uart = 1'b0;
         expect_bit("rx_empty", rx_empty, 1'b1);
         cycles(1);
         expect_byte("r_data", r_data, s.rx_data);  // read leaves data alone
         pending = 1'b0;
      end
   endtask

   task automatic tx_side(input uart_data_t b);
      uart_data_t got;
      int         elapsed;
      int         limit;
      int         i;
      limit = 0;
      while (tx_full !== 1'b0 && limit < FRAME_CLKS) begin
         cycles(1);
         limit++;
      end
      expect_bit("tx_full", tx_full, 1'b0);
      wr_uart = 1'b1;
      w_data  = b;
      cycles(1);
      wr_uart = 1'b0;
      expect_bit("tx_full", tx_full, 1'b1);  // one cycle after the write

      // start bit edge
      limit = 0;
      while (tx !== 1'b0 && limit < BIT_CLKS) begin
         cycles(1);
         limit++;
      end
      assert (tx === 1'b0) else begin
         errors++;
         $display("Transmitter did not start a frame after the write of %h", b);
      end

      cycles(BIT_CLKS / 2);
      elapsed = BIT_CLKS / 2;
      expect_bit("tx start bit", tx, 1'b0);
      expect_bit("tx_full", tx_full, 1'b1);
      for (i = 0; i < DBIT; i++) begin
         cycles(BIT_CLKS);
         elapsed += BIT_CLKS;
         got[i] = tx;
         expect_bit("tx_full", tx_full, 1'b1);
      end
      cycles(BIT_CLKS);
      elapsed += BIT_CLKS;
      expect_bit("tx stop bit", tx, 1'b1);
      expect_bit("tx_full", tx_full, 1'b1);
      expect_byte("tx data", got, b);

      // flag drops right after the last stop tick
      while (tx_full !== 1'b0 && elapsed < FRAME_CLKS + BIT_CLKS) begin
         cycles(1);
         elapsed++;
      end
      assert (elapsed > FRAME_CLKS - DVSR && elapsed <= FRAME_CLKS) else begin
         errors++;
         $display("tx_full fell %0d clocks after the start bit, expected %0d to %0d",
                  elapsed, FRAME_CLKS - DVSR + 1, FRAME_CLKS);
      end
      expect_bit("tx", tx, 1'b1);
   endtask

   initial begin
      stim_t       cur;
      int          i;
      logic [31:0] rnd;

      rst_n   = 1'b0;
      rd_uart = 1'b0;
      wr_uart = 1'b0;
      rx      = 1'b1;  // idle line
      w_data  = '0;
      errors  = 0;
      seed    = 32'h6e7c_451d;
      pending = 1'b0;
      have_rx = 1'b0;
      last_rx = '0;

      stim_q.push_back(make_entry(8'h55, 8'ha5, 1'b0));  // alternating bits
      stim_q.push_back(make_entry(8'h00, 8'hff, 1'b0));
      stim_q.push_back(make_entry(8'hff, 8'h00, 1'b1));  // overwritten by 3c
      stim_q.push_back(make_entry(8'h3c, 8'h81, 1'b0));
      stim_q.push_back(make_entry(8'h01, 8'h80, 1'b1));
      stim_q.push_back(make_entry(8'hc7, 8'h5e, 1'b0));
      for (i = 0; i < NUM_RANDOM; i++) begin
         rnd = $random(seed);
         stim_q.push_back(make_entry(rnd[7:0], rnd[15:8], 1'b0));
      end

      cycles(10);
      rst_n = 1'b1;

      // quiet line for a few ticks after reset
      for (i = 0; i < 3 * DVSR; i++) begin
         cycles(1);
         expect_bit("tx", tx, 1'b1);
         expect_bit("tx_full", tx_full, 1'b0);
         expect_bit("rx_empty", rx_empty, 1'b1);
      end

      // both directions run together for each entry
      for (i = 0; i < stim_q.size(); i++) begin
         cur = stim_q[i];
         fork
            rx_side(cur);
            tx_side(cur.tx_data);
         join
      end

      cycles(BIT_CLKS);
      $display("Finished %0d table entries with %0d errors", stim_q.size(), errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CLKS) @(posedge clk);
      $display("Watchdog expired after %0d clocks, the test did not finish", WATCHDOG_CLKS);
      $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
// Free-running clock for the UART testbench.
// 8 ns period, starts low.
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
   output logic clk
);

   localparam int HALF_PERIOD = 4;  // ns

   initial begin
      clk = 1'b0;
   end

   always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// ==== hdl/uart_ff_buf.sv ====
// UART top level with a one-byte buffer in each direction.
// Host writes with wr_uart while tx_full is low, reads r_data and acks with rd_uart.
`timescale 1ns/100ps
`default_nettype none

module uart_ff_buf (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 rd_uart,
   input  logic                 wr_uart,
   input  logic                 rx,
   input  uart_pkg::uart_data_t w_data,
   output logic                 tx_full,
   output logic                 rx_empty,
   output logic                 tx,
   output uart_pkg::uart_data_t r_data
);
   import uart_pkg::*;

   logic       tick;
   logic       tx_done;
   logic       rx_flag;
   uart_byte_t rx_byte;
   uart_byte_t tx_load;
   uart_data_t tx_dout;

   assign tx_load  = '{valid: wr_uart, data: w_data};
   assign rx_empty = ~rx_flag;

   baud_tick_gen u_baud (
      .clk   (clk),
      .rst_n (rst_n),
      .tick  (tick)
   );

   uart_rx u_rx (
      .clk     (clk),
      .rst_n   (rst_n),
      .tick    (tick),
      .rx      (rx),
      .rx_byte (rx_byte)
   );

   flag_buf u_rx_buf (
      .clk   (clk),
      .rst_n (rst_n),
      .load  (rx_byte),
      .clr   (rd_uart),
      .flag  (rx_flag),
      .dout  (r_data)
   );

   flag_buf u_tx_buf (
      .clk   (clk),
      .rst_n (rst_n),
      .load  (tx_load),
      .clr   (tx_done),
      .flag  (tx_full),  // also the transmitter's start request
      .dout  (tx_dout)
   );

   uart_tx u_tx (
      .clk     (clk),
      .rst_n   (rst_n),
      .tick    (tick),
      .start   (tx_full),
      .din     (tx_dout),
      .tx_done (tx_done),
      .tx      (tx)
   );

endmodule

`default_nettype wire

// ==== hdl/flag_buf.sv ====
// One-byte holding register with a full flag.
// load sets the flag and captures the byte, clr drops the flag, load wins.
`timescale 1ns/100ps
`default_nettype none

module flag_buf (
   input  logic                 clk,
   input  logic                 rst_n,
   input  uart_pkg::uart_byte_t load,
   input  logic                 clr,
   output logic                 flag,
   output uart_pkg::uart_data_t dout
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         flag <= 1'b0;
      end else if (load.valid) begin
         flag <= 1'b1;  // load has priority over clr
      end else if (clr) begin
         flag <= 1'b0;
      end
   end

   // byte register written only by a load
   always_ff @(posedge clk) begin
      if (load.valid) begin
         dout <= load.data;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
// Serial transmitter, sends one 8N1 frame per start request.
// din is captured as the FSM leaves idle; tx_done marks the last stop tick.
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                tick,
   input  logic                start,
   input  uart_pkg::uart_data_t din,
   output logic                tx_done,
   output logic                tx
);
   import uart_pkg::*;

   uart_state_e state;
   tick_cnt_t   s_cnt;
   bit_cnt_t    n_cnt;
   uart_data_t  shreg;   // bit 0 is the bit on the line
   logic        tx_q;
   logic        bit_end;

   assign bit_end = tick && (s_cnt == tick_cnt_t'(OVERSAMPLE - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= st_idle;
         s_cnt <= '0;
         n_cnt <= '0;
         tx_q  <= 1'b1;  // line idles high
      end else begin
         case (state)
            st_idle: begin
               tx_q <= 1'b1;
               if (start) begin
                  state <= st_start;
                  s_cnt <= '0;
                  tx_q  <= 1'b0;  // start bit
               end
            end
            st_start: begin
               if (bit_end) begin
                  state <= st_data;
                  s_cnt <= '0;
                  n_cnt <= '0;
                  tx_q  <= shreg[0];
               end else if (tick) begin
                  s_cnt <= s_cnt + 1'b1;
               end
            end
            st_data: begin
               if (bit_end) begin
                  s_cnt <= '0;
                  if (n_cnt == bit_cnt_t'(DBIT - 1)) begin
                     state <= st_stop;
                     tx_q  <= 1'b1;  // stop bit
                  end else begin
                     n_cnt <= n_cnt + 1'b1;
                     tx_q  <= shreg[1];  // next bit before the shift lands
                  end
               end else if (tick) begin
                  s_cnt <= s_cnt + 1'b1;
               end
            end
            st_stop: begin
               if (tick) begin
                  if (s_cnt == tick_cnt_t'(SB_TICK - 1)) begin
                     state <= st_idle;
                  end else begin
                     s_cnt <= s_cnt + 1'b1;
                  end
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // payload shifter loaded on leaving idle
   always_ff @(posedge clk) begin
      if (state == st_idle && start) begin
         shreg <= din;
      end else if (state == st_data && bit_end) begin
         shreg <= {1'b0, shreg[7:1]};
      end
   end

   assign tx_done = (state == st_stop) && tick && (s_cnt == tick_cnt_t'(SB_TICK - 1));
   assign tx      = tx_q;

   // no frame in flight means a quiet line
   a_idle_line_high: assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == st_idle) |-> tx
   );

endmodule

`default_nettype wire

// ==== hdl/uart_rx.sv ====
// Serial receiver, 16x oversampled, LSB first, one stop bit.
// Each finished byte is presented on rx_byte with a one-cycle valid.
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                tick,
   input  logic                rx,
   output uart_pkg::uart_byte_t rx_byte
);
   import uart_pkg::*;

   uart_state_e state;
   tick_cnt_t   s_cnt;   // ticks within the current bit
   bit_cnt_t    n_cnt;   // data bits received so far
   uart_data_t  shreg;
   logic        rx_prev; // for start edge detection
   logic        done;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_prev <= 1'b1;  // idle line is high
      end else begin
         rx_prev <= rx;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= st_idle;
         s_cnt <= '0;
         n_cnt <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (rx_prev && !rx) begin  // falling edge
                  state <= st_start;
                  s_cnt <= '0;
               end
            end
            st_start: begin
               if (tick) begin
                  // middle of the start bit
                  if (s_cnt == tick_cnt_t'(OVERSAMPLE / 2 - 1)) begin
                     s_cnt <= '0;
                     n_cnt <= '0;
                     state <= rx ? st_idle : st_data;  // glitch goes back to idle
                  end else begin
                     s_cnt <= s_cnt + 1'b1;
                  end
               end
            end
            st_data: begin
               if (tick) begin
                  if (s_cnt == tick_cnt_t'(OVERSAMPLE - 1)) begin
                     s_cnt <= '0;
                     if (n_cnt == bit_cnt_t'(DBIT - 1)) begin
                        state <= st_stop;
                     end else begin
                        n_cnt <= n_cnt + 1'b1;
                     end
                  end else begin
                     s_cnt <= s_cnt + 1'b1;
                  end
               end
            end
            st_stop: begin
               if (tick) begin
                  if (s_cnt == tick_cnt_t'(SB_TICK - 1)) begin
                     state <= st_idle;
                  end else begin
                     s_cnt <= s_cnt + 1'b1;
                  end
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // LSB arrives first so shift right
   always_ff @(posedge clk) begin
      if (state == st_data && tick && s_cnt == tick_cnt_t'(OVERSAMPLE - 1)) begin
         shreg <= {rx, shreg[7:1]};
      end
   end

   assign done = (state == st_stop) && tick && (s_cnt == tick_cnt_t'(SB_TICK - 1));

   assign rx_byte.valid = done;
   assign rx_byte.data  = shreg;

   // FSM leaves stop on the valid edge so the strobe is a single cycle
   a_valid_one_cycle: assert property (
      @(posedge clk) disable iff (!rst_n)
      rx_byte.valid |=> !rx_byte.valid
   );

endmodule

`default_nettype wire

// ==== hdl/baud_tick_gen.sv ====
// Oversampling tick source, one pulse every DVSR clocks.
// Shared by the receiver and the transmitter.
`timescale 1ns/100ps
`default_nettype none

module baud_tick_gen (
   input  logic clk,
   input  logic rst_n,
   output logic tick
);
   import uart_pkg::*;

   baud_cnt_t cnt;
   logic      wrap;

   assign wrap = (cnt == baud_cnt_t'(DVSR - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt  <= '0;
         tick <= 1'b0;
      end else begin
         // registered so the first tick lands DVSR clocks after reset
         tick <= wrap;
         if (wrap) begin
            cnt <= '0;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   // divider must never collapse to a back-to-back tick
   a_tick_spaced: assert property (
      @(posedge clk) disable iff (!rst_n)
      tick |=> !tick
   );

endmodule

`default_nettype wire

// ==== hdl/uart_pkg.sv ====
// Shared constants, types and state encoding for the UART subsystem.
// Fixed 8N1 line format, 16x oversampling, about 19,200 baud from a 65 MHz clock.
`default_nettype none

package uart_pkg;

   // line format
   localparam int DBIT       = 8;   // data bits per frame
   localparam int SB_TICK    = 16;  // ticks in the stop bit
   localparam int OVERSAMPLE = 16;  // ticks per bit

   // 65 MHz / (16 * 19200) rounded to the nearest clock
   localparam int DVSR = 212;

   typedef logic [7:0] uart_data_t;  // one data byte
   typedef logic [7:0] baud_cnt_t;   // divider count up to DVSR-1
   typedef logic [4:0] tick_cnt_t;   // ticks within a bit
   typedef logic [2:0] bit_cnt_t;    // data bit index

   // byte plus its one-cycle strobe
   typedef struct packed {
      logic       valid;
      uart_data_t data;
   } uart_byte_t;

   // shared by receiver and transmitter
   typedef enum logic [1:0] {
      st_idle,
      st_start,
      st_data,
      st_stop
   } uart_state_e;

endpackage

`default_nettype wire
